// File: verilog/emu_pack.sv
// default sizes for the receiver front-end model
// the top level takes these as parameter defaults and the testbench sizes its models from them
package emu_pack;

    // history bits looked up per table access
    localparam int chunk_width_def = 4;

    // chunks walked per frame
    localparam int num_chunks_def = 4;

    // interleaved slices, also the bits taken in per frame
    localparam int num_slices_def = 4;

    // step-response entries and accumulators share this width
    localparam int func_width_def = 18;

    // width of each slice's magnitude output
    localparam int adc_width_def = 8;

    // right shift from absolute sum to ADC code
    localparam int adc_shift_def = 4;

endpackage

// File: verilog/chan_ram.sv
`timescale 1ns/10ps

// step-response table for one slice
// addressed by {chunk index, chunk value}, one signed entry per location
module chan_ram #(
    parameter int chunk_width = emu_pack::chunk_width_def,
    parameter int num_chunks  = emu_pack::num_chunks_def,
    parameter int func_width  = emu_pack::func_width_def,
    localparam int ram_addr_width = $clog2(num_chunks) + chunk_width
) (
    input  logic                      emu_clk,
    input  logic                      we_i,     // write strobe, already slice-qualified
    input  logic [ram_addr_width-1:0] waddr_i,
    input  logic [func_width-1:0]     wdata_i,
    input  logic [ram_addr_width-1:0] raddr_i,
    output logic [func_width-1:0]     rdata_o   // valid one cycle after raddr_i
);

    localparam int depth = num_chunks * (2 ** chunk_width);

    logic [func_width-1:0] mem [depth];

    // write port
    always_ff @(posedge emu_clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, maps onto block RAM output register
    always_ff @(posedge emu_clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: verilog/analog_slice.sv
`timescale 1ns/10ps

// one interleaved ADC slice
// sums the step-response contributions of every chunk in the frame, then
// quantizes the total to sign and saturated magnitude
module analog_slice #(
    parameter int slice_index = 0,
    parameter int chunk_width = emu_pack::chunk_width_def,
    parameter int num_chunks  = emu_pack::num_chunks_def,
    parameter int num_slices  = emu_pack::num_slices_def,
    parameter int func_width  = emu_pack::func_width_def,
    parameter int adc_width   = emu_pack::adc_width_def,
    parameter int adc_shift   = emu_pack::adc_shift_def,
    localparam int chunk_idx_width = $clog2(num_chunks),
    localparam int addr_width = $clog2(num_slices) + chunk_idx_width + chunk_width
) (
    input  logic                       emu_clk,
    input  logic                       emu_rst,
    input  logic [chunk_width-1:0]     chunk_i,      // history bits for this cycle
    input  logic [chunk_idx_width-1:0] chunk_idx_i,  // position of chunk_i in the history
    input  logic                       load_i,       // first entry of the frame arrives
    input  logic                       add_i,        // later entries arrive
    input  logic                       write_out_i,  // sum is complete
    input  logic                       we_i,
    input  logic [addr_width-1:0]      waddr_i,      // {slice, chunk index, chunk value}
    input  logic [func_width-1:0]      wdata_i,
    output logic                       sign_o,       // 1 for a non-negative sum
    output logic [adc_width-1:0]       mag_o
);

    localparam int ram_addr_width = chunk_idx_width + chunk_width;
    localparam int slice_sel_width = $clog2(num_slices);
    localparam logic [func_width-1:0] mag_max = func_width'((1 << adc_width) - 1);

    logic                      ram_we;
    logic [ram_addr_width-1:0] raddr;
    logic [func_width-1:0]     rdata;
    logic signed [func_width-1:0] entry;
    logic signed [func_width-1:0] acc;
    logic [func_width-1:0]     abs_sum;
    logic [func_width-1:0]     shifted;
    logic [func_width-1:0]     sat;

    // this slice claims writes whose slice field matches its index
    assign ram_we = we_i &&
        (waddr_i[addr_width-1 -: slice_sel_width] == slice_sel_width'(slice_index));

    assign raddr = {chunk_idx_i, chunk_i};

    chan_ram #(
        .chunk_width (chunk_width),
        .num_chunks  (num_chunks),
        .func_width  (func_width)
    ) u_chan_ram (
        .emu_clk (emu_clk),
        .we_i    (ram_we),
        .waddr_i (waddr_i[ram_addr_width-1:0]),
        .wdata_i (wdata_i),
        .raddr_i (raddr),
        .rdata_o (rdata)
    );

    assign entry = rdata;

    // running sum over the frame, wraps modulo 2**func_width
    always_ff @(posedge emu_clk) begin
        if (load_i) begin
            acc <= entry;
        end else if (add_i) begin
            acc <= acc + entry;
        end
    end

    // quantizer
    assign abs_sum = acc[func_width-1] ? -acc : acc;  // most negative value stays representable
    assign shifted = abs_sum >> adc_shift;
    assign sat     = (shifted > mag_max) ? mag_max : shifted;

    // output codes, reset to the zero-sum result
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            sign_o <= 1'b1;
            mag_o  <= '0;
        end else if (write_out_i) begin
            sign_o <= ~acc[func_width-1];
            mag_o  <= sat[adc_width-1:0];
        end
    end

endmodule

// File: verilog/analog_core.sv
`timescale 1ns/10ps

// receiver front-end core
// keeps the received bit history, walks it one chunk per cycle, runs the
// slice array and derives the divided ADC clock from the frame counter
module analog_core #(
    parameter int chunk_width = emu_pack::chunk_width_def,
    parameter int num_chunks  = emu_pack::num_chunks_def,
    parameter int num_slices  = emu_pack::num_slices_def,
    parameter int func_width  = emu_pack::func_width_def,
    parameter int adc_width   = emu_pack::adc_width_def,
    parameter int adc_shift   = emu_pack::adc_shift_def,
    localparam int addr_width = $clog2(num_slices) + $clog2(num_chunks) + chunk_width
) (
    input  logic                                emu_clk,
    input  logic                                emu_rst,
    input  logic [num_slices-1:0]               rx_data_i,   // taken on sample_req_o
    input  logic                                chan_we_i,
    input  logic [addr_width-1:0]               chan_waddr_i,
    input  logic [func_width-1:0]               chan_wdata_i,
    output logic                                sample_req_o,
    output logic [num_slices-1:0]               sign_o,
    output logic [num_slices-1:0][adc_width-1:0] mag_o,
    output logic                                clk_adc_o
);

    localparam int chunk_idx_width = $clog2(num_chunks);
    localparam int hist_width = num_chunks * chunk_width;
    localparam int cnt_width = $clog2(num_chunks + 2);

    // ADC clock edges within the frame, roughly 50% duty
    localparam int clock_fall = 2;
    localparam int clock_rise = 1 + (num_chunks + 2) / 2;

    localparam logic [cnt_width-1:0] last_count = cnt_width'(num_chunks + 1);
    localparam logic [cnt_width-1:0] chunk_end = cnt_width'(num_chunks);
    localparam logic [cnt_width-1:0] fall_count = cnt_width'(clock_fall);
    localparam logic [cnt_width-1:0] rise_count = cnt_width'(clock_rise);

    logic [cnt_width-1:0]       counter;
    logic [hist_width-1:0]      history;
    logic [chunk_idx_width-1:0] chunk_idx;
    logic [chunk_width-1:0]     chunk;
    logic                       load_sum;
    logic                       add_sum;
    logic                       last_cycle;

    // frame counter, num_chunks+2 cycles per frame
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            counter <= '0;
        end else if (counter == last_count) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // shared per-frame strobes
    assign last_cycle = (counter == last_count);
    assign load_sum   = (counter == cnt_width'(1));                      // entry for chunk 0
    assign add_sum    = (counter >= cnt_width'(2)) && (counter <= chunk_end);
    assign chunk_idx  = (counter < chunk_end) ? counter[chunk_idx_width-1:0] : '0;

    assign sample_req_o = last_cycle;

    // newest bits enter at the top, oldest fall off the bottom
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            history <= '0;
        end else if (last_cycle) begin
            history <= {rx_data_i, history[hist_width-1:num_slices]};
        end
    end

    // chunk 0 is the most significant slice of the history
    assign chunk = history[hist_width - 1 - chunk_width * int'(chunk_idx) -: chunk_width];

    // slice array
    for (genvar i = 0; i < num_slices; i++) begin : g_slice
        analog_slice #(
            .slice_index (i),
            .chunk_width (chunk_width),
            .num_chunks  (num_chunks),
            .num_slices  (num_slices),
            .func_width  (func_width),
            .adc_width   (adc_width),
            .adc_shift   (adc_shift)
        ) u_slice (
            .emu_clk     (emu_clk),
            .emu_rst     (emu_rst),
            .chunk_i     (chunk),
            .chunk_idx_i (chunk_idx),
            .load_i      (load_sum),
            .add_i       (add_sum),
            .write_out_i (last_cycle),
            .we_i        (chan_we_i),     // each slice matches the slice field itself
            .waddr_i     (chan_waddr_i),
            .wdata_i     (chan_wdata_i),
            .sign_o      (sign_o[i]),
            .mag_o       (mag_o[i])
        );
    end

    // ADC clock is low from clock_fall through clock_rise
    assign clk_adc_o = ((counter >= fall_count) && (counter <= rise_count)) ? 1'b0 : 1'b1;

endmodule

// File: verilog/adc_retimer.sv
`timescale 1ns/10ps

// moves the slice outputs into the ADC clock domain view
// the ADC clock is sampled on emu_clk and a rising edge triggers a capture
module adc_retimer #(
    parameter int num_slices = emu_pack::num_slices_def,
    parameter int adc_width  = emu_pack::adc_width_def
) (
    input  logic                                 emu_clk,
    input  logic                                 emu_rst,
    input  logic                                 clk_adc_i,
    input  logic [num_slices-1:0]                sign_i,
    input  logic [num_slices-1:0][adc_width-1:0] mag_i,
    output logic [num_slices-1:0]                sign_o,
    output logic [num_slices-1:0][adc_width-1:0] mag_o,
    output logic                                 adc_valid_o  // one cycle per ADC clock
);

    logic clk_d1;
    logic clk_d2;
    logic clk_rise;

    // both stages start high so the first frame cannot look like an edge
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            clk_d1 <= 1'b1;
            clk_d2 <= 1'b1;
        end else begin
            clk_d1 <= clk_adc_i;
            clk_d2 <= clk_d1;
        end
    end

    assign clk_rise = clk_d1 & ~clk_d2;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            adc_valid_o <= 1'b0;
        end else begin
            adc_valid_o <= clk_rise;
        end
    end

    // captured words hold until the next edge
    always_ff @(posedge emu_clk) begin
        if (clk_rise) begin
            sign_o <= sign_i;
            mag_o  <= mag_i;
        end
    end

endmodule

// File: verilog/rx_emu_top.sv
`timescale 1ns/10ps

// receiver emulation top: front-end core followed by the output retimer
module rx_emu_top #(
    parameter int chunk_width = emu_pack::chunk_width_def,
    parameter int num_chunks  = emu_pack::num_chunks_def,
    parameter int num_slices  = emu_pack::num_slices_def,
    parameter int func_width  = emu_pack::func_width_def,
    parameter int adc_width   = emu_pack::adc_width_def,
    parameter int adc_shift   = emu_pack::adc_shift_def,
    localparam int addr_width = $clog2(num_slices) + $clog2(num_chunks) + chunk_width
) (
    input  logic                                 emu_clk,
    input  logic                                 emu_rst,
    input  logic [num_slices-1:0]                rx_data_i,
    input  logic                                 chan_we_i,
    input  logic [addr_width-1:0]                chan_waddr_i,
    input  logic [func_width-1:0]                chan_wdata_i,
    output logic                                 sample_req_o,
    output logic [num_slices-1:0]                sign_o,
    output logic [num_slices-1:0][adc_width-1:0] mag_o,
    output logic                                 clk_adc_o,
    output logic                                 adc_valid_o
);

    logic [num_slices-1:0]                core_sign;
    logic [num_slices-1:0][adc_width-1:0] core_mag;

    analog_core #(
        .chunk_width (chunk_width),
        .num_chunks  (num_chunks),
        .num_slices  (num_slices),
        .func_width  (func_width),
        .adc_width   (adc_width),
        .adc_shift   (adc_shift)
    ) u_analog_core (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .rx_data_i    (rx_data_i),
        .chan_we_i    (chan_we_i),
        .chan_waddr_i (chan_waddr_i),
        .chan_wdata_i (chan_wdata_i),
        .sample_req_o (sample_req_o),
        .sign_o       (core_sign),
        .mag_o        (core_mag),
        .clk_adc_o    (clk_adc_o)
    );

    adc_retimer #(
        .num_slices (num_slices),
        .adc_width  (adc_width)
    ) u_adc_retimer (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .clk_adc_i   (clk_adc_o),
        .sign_i      (core_sign),
        .mag_i       (core_mag),
        .sign_o      (sign_o),
        .mag_o       (mag_o),
        .adc_valid_o (adc_valid_o)
    );

endmodule

// File: sim/rx_emu_assertions.sv
`timescale 1ns/10ps

// frame and ADC clock timing properties, bound into the core and the retimer
module rx_emu_assertions #(
    parameter int num_chunks = emu_pack::num_chunks_def,
    parameter bit core_side  = 1'b1
) (
    input logic emu_clk,
    input logic emu_rst,
    input logic sample_req_i,
    input logic clk_adc_i,
    input logic adc_valid_i
);

    import emu_pack::*;

    localparam int frame_len  = num_chunks + 2;
    localparam int clock_rise = 1 + frame_len / 2;

    int   req_gap;      // cycles since the last sample strobe
    int   low_run;      // consecutive low cycles of the ADC clock
    logic clk_prev;
    int   valid_gap;    // cycles since the last valid pulse
    logic valid_seen;
    int   error_count = 0;  // failed assertions so far

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            req_gap    <= 0;
            low_run    <= 0;
            clk_prev   <= 1'b1;
            valid_gap  <= 0;
            valid_seen <= 1'b0;
        end else begin
            req_gap    <= sample_req_i ? 0 : req_gap + 1;
            low_run    <= clk_adc_i ? 0 : low_run + 1;
            clk_prev   <= clk_adc_i;
            valid_gap  <= adc_valid_i ? 0 : valid_gap + 1;
            valid_seen <= valid_seen | adc_valid_i;
        end
    end

    if (core_side) begin : g_core
        a_req_period : assert property (@(posedge emu_clk) disable iff (emu_rst)
            sample_req_i |-> (req_gap == frame_len - 1))
            else begin
                error_count++;
                $error("sample strobe spacing differs from the frame length");
            end

        a_req_missing : assert property (@(posedge emu_clk) disable iff (emu_rst)
            req_gap < frame_len)
            else begin
                error_count++;
                $error("sample strobe missing within a frame");
            end

        a_clk_low : assert property (@(posedge emu_clk) disable iff (emu_rst)
            (clk_adc_i && !clk_prev) |-> (low_run == clock_rise - 1))
            else begin
                error_count++;
                $error("ADC clock low phase has the wrong length");
            end
    end else begin : g_retimer
        // a pulse held two cycles shows up as a gap of zero
        a_valid_pulse : assert property (@(posedge emu_clk) disable iff (emu_rst)
            (adc_valid_i && valid_seen) |-> (valid_gap == frame_len - 1))
            else begin
                error_count++;
                $error("adc_valid_o pulses are not exactly one frame apart");
            end
    end

endmodule

bind analog_core rx_emu_assertions #(
    .num_chunks (num_chunks),
    .core_side  (1'b1)
) u_core_assertions (
    .emu_clk      (emu_clk),
    .emu_rst      (emu_rst),
    .sample_req_i (sample_req_o),
    .clk_adc_i    (clk_adc_o),
    .adc_valid_i  (1'b0)
);

bind adc_retimer rx_emu_assertions #(
    .core_side (1'b0)
) u_retimer_assertions (
    .emu_clk      (emu_clk),
    .emu_rst      (emu_rst),
    .sample_req_i (1'b0),
    .clk_adc_i    (clk_adc_i),
    .adc_valid_i  (adc_valid_o)
);

// File: sim/rx_emu_checker.sv
`timescale 1ns/10ps

// watches the DUT ports, models the tables and history, and compares every valid word
module rx_emu_checker #(
    parameter int chunk_width = emu_pack::chunk_width_def,
    parameter int num_chunks  = emu_pack::num_chunks_def,
    parameter int num_slices  = emu_pack::num_slices_def,
    parameter int func_width  = emu_pack::func_width_def,
    parameter int adc_width   = emu_pack::adc_width_def,
    parameter int adc_shift   = emu_pack::adc_shift_def,
    localparam int addr_width = $clog2(num_slices) + $clog2(num_chunks) + chunk_width
) (
    input  logic                                 emu_clk,
    input  logic                                 emu_rst,
    input  logic                                 armed_i,   // tables are stable
    input  int                                   phase_i,
    input  logic [num_slices-1:0]                rx_data_i,
    input  logic                                 chan_we_i,
    input  logic [addr_width-1:0]                chan_waddr_i,
    input  logic [func_width-1:0]                chan_wdata_i,
    input  logic                                 sample_req_i,
    input  logic [num_slices-1:0]                sign_i,
    input  logic [num_slices-1:0][adc_width-1:0] mag_i,
    input  logic                                 adc_valid_i,
    output int                                   pass_count_o,
    output int                                   fail_count_o
);

    import emu_pack::*;

    localparam int hist_width = num_chunks * chunk_width;
    localparam int frame_len  = num_chunks + 2;
    localparam int entries    = 2 ** chunk_width;
    localparam int idx_width  = $clog2(num_chunks);
    localparam int mag_max    = (1 << adc_width) - 1;

    int tbl [num_slices][num_chunks][entries];  // copy of every slice table
    logic [hist_width-1:0] hist_cur;
    logic [hist_width-1:0] hist_prev;           // history before the latest strobe
    int strobes;
    int since_req;
    int since_valid;
    int since_rst;
    int pulse_num;
    bit seen_req;
    bit seen_valid;

    function automatic string test_name(input int phase);
        case (phase)
            1: return "after_reset";
            2: return "random";
            3: return "saturation";
            4: return "negative";
            5: return "slice_independence";
            default: return "unnamed";
        endcase
    endfunction

    // expected slice outputs for one history value
    function automatic void ref_word(input logic [hist_width-1:0] hist,
                                     output logic [num_slices-1:0] exp_sign,
                                     output logic [num_slices-1:0][adc_width-1:0] exp_mag);
        int sum;
        int absv;
        int val;
        for (int s = 0; s < num_slices; s++) begin
            sum = 0;
            for (int k = 0; k < num_chunks; k++) begin
                val = int'(hist[hist_width - 1 - chunk_width * k -: chunk_width]);
                sum += tbl[s][k][val];
            end
            exp_sign[s] = (sum >= 0);
            absv = (sum < 0) ? -sum : sum;
            absv = absv >> adc_shift;
            if (absv > mag_max) absv = mag_max;
            exp_mag[s] = adc_width'(absv);
        end
    endfunction

    function automatic void report_timing(input string what);
        $display("timing error at %0t: %s", $time, what);
        fail_count_o++;
    endfunction

    initial begin
        pass_count_o = 0;
        fail_count_o = 0;
    end

    always @(posedge emu_clk) begin
        logic [num_slices-1:0]                exp_sign;
        logic [num_slices-1:0][adc_width-1:0] exp_mag;
        if (chan_we_i) begin
            tbl[int'(chan_waddr_i >> (idx_width + chunk_width))]
               [int'((chan_waddr_i >> chunk_width) & addr_width'(num_chunks - 1))]
               [int'(chan_waddr_i & addr_width'(entries - 1))] = int'($signed(chan_wdata_i));
        end
        if (emu_rst) begin
            hist_cur   = '0;
            hist_prev  = '0;
            strobes    = 0;
            since_rst  = 0;
            since_req  = 0;
            since_valid = 0;
            seen_req   = 0;
            seen_valid = 0;
        end else begin
            if (!armed_i) strobes = 0;
            if (since_rst < frame_len - 1 && (sample_req_i || adc_valid_i)) begin
                report_timing("strobe or valid pulse during the first frame after reset");
            end
            since_rst++;
            since_req++;
            since_valid++;
            if (seen_req && since_req == frame_len + 1) report_timing("sample strobe missing");
            if (seen_valid && since_valid == frame_len + 1) report_timing("valid pulse missing");
            if (adc_valid_i) begin
                if (seen_req && since_req != 2) report_timing("valid pulse not at counter 1");
                if (seen_valid && since_valid != frame_len) report_timing("extra valid pulse");
                since_valid = 0;
                seen_valid  = 1;
                if (armed_i && strobes >= 3) begin
                    pulse_num++;
                    ref_word(hist_prev, exp_sign, exp_mag);
                    if ({sign_i, mag_i} !== {exp_sign, exp_mag}) begin
                        $display("Fail %s pulse %0d: expected sign %b mag %h, actual sign %b mag %h",
                                 test_name(phase_i), pulse_num, exp_sign, exp_mag, sign_i, mag_i);
                        fail_count_o++;
                    end else begin
                        $display("pass %s pulse %0d", test_name(phase_i), pulse_num);
                        pass_count_o++;
                    end
                end
            end
            if (sample_req_i) begin
                if (seen_req && since_req != frame_len) report_timing("extra sample strobe");
                since_req = 0;
                seen_req  = 1;
                hist_prev = hist_cur;
                hist_cur  = {rx_data_i, hist_cur[hist_width-1:num_slices]};
                if (armed_i) strobes++;
            end
        end
    end

endmodule

// File: sim/tb_rx_emu.sv
`timescale 1ns/10ps

module tb_rx_emu;

    import emu_pack::*;

    localparam int cw         = chunk_width_def;
    localparam int nc         = num_chunks_def;
    localparam int ns         = num_slices_def;
    localparam int fw         = func_width_def;
    localparam int aw         = adc_width_def;
    localparam int addr_width = $clog2(ns) + $clog2(nc) + cw;
    localparam int entries    = 2 ** cw;
    localparam int frame_len  = nc + 2;
    localparam int table_size = ns * nc * entries;
    localparam int test_frames = 6 + 40 + 8 + 10 + 10 + 2;
    localparam int timeout_cycles = 2 * 16 + 4 * (table_size + 2)
                                    + test_frames * frame_len * 2;

    logic                  emu_clk;
    logic                  emu_rst;
    logic [ns-1:0]         rx_data;
    logic                  chan_we;
    logic [addr_width-1:0] chan_waddr;
    logic [fw-1:0]         chan_wdata;
    logic                  sample_req;
    logic [ns-1:0]         sign;
    logic [ns-1:0][aw-1:0] mag;
    logic                  clk_adc;
    logic                  adc_valid;
    logic                  armed;
    int                    phase;
    int                    pass_count;
    int                    fail_count;
    int                    assert_fails;
    int unsigned           seed_val;

    always #4 emu_clk = ~emu_clk;

    rx_emu_top u_rx_emu_top (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .rx_data_i    (rx_data),
        .chan_we_i    (chan_we),
        .chan_waddr_i (chan_waddr),
        .chan_wdata_i (chan_wdata),
        .sample_req_o (sample_req),
        .sign_o       (sign),
        .mag_o        (mag),
        .clk_adc_o    (clk_adc),
        .adc_valid_o  (adc_valid)
    );

    rx_emu_checker u_checker (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .armed_i      (armed),
        .phase_i      (phase),
        .rx_data_i    (rx_data),
        .chan_we_i    (chan_we),
        .chan_waddr_i (chan_waddr),
        .chan_wdata_i (chan_wdata),
        .sample_req_i (sample_req),
        .sign_i       (sign),
        .mag_i        (mag),
        .adc_valid_i  (adc_valid),
        .pass_count_o (pass_count),
        .fail_count_o (fail_count)
    );

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % unsigned'(hi - lo + 1));
    endfunction

    task automatic write_entry(input int s, input int k, input int v, input int data);
        @(posedge emu_clk);
        #1;
        chan_we    = 1'b1;
        chan_waddr = addr_width'((s << ($clog2(nc) + cw)) | (k << cw) | v);
        chan_wdata = fw'(data);
    endtask

    // mode 0 random with zero at chunk value 0, 1 large positive, 2 negative, 3 random
    task automatic load_slice(input int s, input int mode);
        int data;
        for (int k = 0; k < nc; k++) begin
            for (int v = 0; v < entries; v++) begin
                case (mode)
                    0: data = (v == 0) ? 0 : rand_range(-2047, 2047);
                    1: data = 20000;
                    2: data = rand_range(-1000, -1);
                    default: data = rand_range(-2047, 2047);
                endcase
                write_entry(s, k, v, data);
            end
        end
    endtask

    task automatic finish_writes();
        @(posedge emu_clk);
        #1;
        chan_we = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge emu_clk);
        #1;
        emu_rst = 1'b1;
        repeat (16) @(posedge emu_clk);
        #1;
        emu_rst = 1'b0;
    endtask

    // a new word goes out during each strobe cycle
    task automatic run_frames(input int n, input bit random_data);
        repeat (n) begin
            do begin
                @(posedge emu_clk);
                #1;
            end while (!sample_req);
            rx_data = random_data ? ns'($urandom) : '0;
        end
    endtask

    initial begin
        seed_val   = $urandom(32'h6ea1c981);
        emu_clk    = 1'b0;
        emu_rst    = 1'b1;
        rx_data    = '0;
        chan_we    = 1'b0;
        chan_waddr = '0;
        chan_wdata = '0;
        armed      = 1'b0;
        phase      = 0;
        fork
            begin
                repeat (16) @(posedge emu_clk);
                #1;
                emu_rst = 1'b0;
            end
            begin
                for (int s = 0; s < ns; s++) load_slice(s, 0);
                finish_writes();
            end
        join
        apply_reset();        // history back to zero with tables in place
        phase = 1;
        armed = 1'b1;
        run_frames(6, 1'b0);
        phase = 2;
        run_frames(40, 1'b1);
        armed = 1'b0;
        phase = 3;
        for (int s = 0; s < ns; s++) load_slice(s, 1);
        finish_writes();
        armed = 1'b1;
        run_frames(8, 1'b1);
        armed = 1'b0;
        phase = 4;
        for (int s = 0; s < ns; s++) load_slice(s, 2);
        finish_writes();
        armed = 1'b1;
        run_frames(10, 1'b1);
        armed = 1'b0;
        phase = 5;
        load_slice(2, 3);     // others keep their negative tables
        finish_writes();
        armed = 1'b1;
        run_frames(10, 1'b1);
        repeat (2 * frame_len) @(posedge emu_clk);
        assert_fails = u_rx_emu_top.u_analog_core.u_core_assertions.error_count
                       + u_rx_emu_top.u_adc_retimer.u_retimer_assertions.error_count;
        $display("tests passed %0d failed %0d", pass_count, fail_count + assert_fails);
        if (fail_count == 0 && assert_fails == 0 && pass_count > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_cycles * 8);
        $display("timeout: the run did not finish in %0d cycles", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: rx_emu.f
verilog/emu_pack.sv
verilog/chan_ram.sv
verilog/analog_slice.sv
verilog/analog_core.sv
verilog/adc_retimer.sv
verilog/rx_emu_top.sv
sim/rx_emu_assertions.sv
sim/rx_emu_checker.sv
sim/tb_rx_emu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the receiver emulation testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rx_emu \
    -f rx_emu.f \
    -o Vtb_rx_emu

output=$(./obj_dir/Vtb_rx_emu)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
